//--- src/alu_pipe_pkg.sv
`default_nettype none

package alu_pipe_pkg;

  localparam int XLEN         = 32;
  localparam int RNID_W       = 6;   // Renamed register number, 0 is x0
  localparam int TGT_BUS_SIZE = 2;

  // Multiplier geometry
  localparam int MUL_UNROLL = 8;
  localparam int MUL_STAGES = XLEN / MUL_UNROLL;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [RNID_W-1:0] rnid_t;

  typedef enum logic [4:0] {
    OP_NONE,
    OP_LUI,
    OP_AUIPC,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU,
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU
  } op_t;

  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_I,    // Sign-extended inst[31:20]
    IMM_SH    // Zero-extended shamt
  } imm_t;

  // ------------------------------------------------------------------------
  // Major opcodes
  // ------------------------------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

endpackage

`default_nettype wire

//--- src/mul_req_if.sv
`default_nettype none

interface mul_req_if
  import alu_pipe_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8
);

  logic                     valid;
  op_t                      op;
  xlen_t                    rs1;
  xlen_t                    rs2;
  rnid_t                    rd_rnid;
  logic                     wr;
  logic [RV_ENTRY_SIZE-1:0] index;

  modport master (output valid, op, rs1, rs2, rd_rnid, wr, index);
  modport slave  (input  valid, op, rs1, rs2, rd_rnid, wr, index);

endinterface

`default_nettype wire

//--- src/wb_if.sv
`default_nettype none

interface wb_if
  import alu_pipe_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8
);

  logic                     done;
  logic                     wr;
  rnid_t                    rd_rnid;
  xlen_t                    data;
  logic [RV_ENTRY_SIZE-1:0] index_oh;

  modport master (output done, wr, rd_rnid, data, index_oh);
  modport slave  (input  done, wr, rd_rnid, data, index_oh);

endinterface

`default_nettype wire

//--- src/alu_decoder.sv
`default_nettype none

module alu_decoder
  import alu_pipe_pkg::*;
(
  input  wire xlen_t i_inst,
  output op_t        o_op,
  output imm_t       o_imm,
  output logic       o_wr
);

  logic [6:0] w_opcode;
  logic [2:0] w_f3;
  logic [6:0] w_f7;

  assign w_opcode = i_inst[6:0];
  assign w_f3     = i_inst[14:12];
  assign w_f7     = i_inst[31:25];

  always_comb begin
    o_op  = OP_NONE;
    o_imm = IMM_NONE;
    case (w_opcode)
      OPC_LUI:   o_op = OP_LUI;
      OPC_AUIPC: o_op = OP_AUIPC;
      OPC_OP_IMM: begin
        o_imm = IMM_I;
        case (w_f3)
          3'b000: o_op = OP_ADD;
          3'b010: o_op = OP_SLT;
          3'b011: o_op = OP_SLTU;
          3'b100: o_op = OP_XOR;
          3'b110: o_op = OP_OR;
          3'b111: o_op = OP_AND;
          3'b001: begin
            o_imm = IMM_SH;
            if (w_f7 == 7'b0000000) o_op = OP_SLL;
          end
          default: begin
            o_imm = IMM_SH;
            if (w_f7 == 7'b0000000) o_op = OP_SRL;
            else if (w_f7 == 7'b0100000) o_op = OP_SRA;
          end
        endcase
      end
      OPC_OP: begin
        case ({w_f7, w_f3})
          10'b0000000_000: o_op = OP_ADD;
          10'b0100000_000: o_op = OP_SUB;
          10'b0000000_001: o_op = OP_SLL;
          10'b0000000_010: o_op = OP_SLT;
          10'b0000000_011: o_op = OP_SLTU;
          10'b0000000_100: o_op = OP_XOR;
          10'b0000000_101: o_op = OP_SRL;
          10'b0100000_101: o_op = OP_SRA;
          10'b0000000_110: o_op = OP_OR;
          10'b0000000_111: o_op = OP_AND;
          10'b0000001_000: o_op = OP_MUL;
          10'b0000001_001: o_op = OP_MULH;
          10'b0000001_010: o_op = OP_MULHSU;
          10'b0000001_011: o_op = OP_MULHU;
          default:         o_op = OP_NONE;
        endcase
      end
      default: o_op = OP_NONE;
    endcase
    // No write for unknown encodings or rd = x0
    o_wr = (o_op != OP_NONE) && (i_inst[11:7] != 5'd0);
  end

endmodule

`default_nettype wire

//--- src/int_exec_pipe.sv
`default_nettype none

module int_exec_pipe
  import alu_pipe_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8
) (
  input  wire                     i_clk,
  input  wire                     i_reset_n,
  input  wire                     i_valid,
  input  wire xlen_t              i_inst,
  input  wire xlen_t              i_pc,
  input  wire op_t                i_op,
  input  wire imm_t               i_imm,
  input  wire                     i_wr,
  input  wire rnid_t              i_rs1_rnid,
  input  wire                     i_rs1_used,
  input  wire rnid_t              i_rs2_rnid,
  input  wire                     i_rs2_used,
  input  wire rnid_t              i_rd_rnid,
  input  wire [RV_ENTRY_SIZE-1:0] i_index,
  output logic                    o_rs1_read,
  output rnid_t                   o_rs1_rnid,
  output logic                    o_rs2_read,
  output rnid_t                   o_rs2_rnid,
  input  wire xlen_t              i_rs1_data,
  input  wire xlen_t              i_rs2_data,
  input  wire                     i_fwd_valid [TGT_BUS_SIZE],
  input  wire rnid_t              i_fwd_rnid  [TGT_BUS_SIZE],
  input  wire xlen_t              i_fwd_data  [TGT_BUS_SIZE],
  mul_req_if.master               mul,
  wb_if.master                    wb
);

  localparam int SH_W = $clog2(XLEN);

  typedef struct packed {
    xlen_t                    inst;
    xlen_t                    pc;
    op_t                      op;
    imm_t                     imm;
    logic                     wr;
    rnid_t                    rs1;
    logic                     rs1_used;
    rnid_t                    rs2;
    logic                     rs2_used;
    rnid_t                    rd;
    logic [RV_ENTRY_SIZE-1:0] index;
  } ctrl_t;

  logic  r_ex1_valid, r_ex2_valid, r_ex3_valid;
  ctrl_t r_ex1, r_ex2;
  xlen_t w_ex1_rs2;
  xlen_t r_ex2_rs1, r_ex2_rs2;
  logic [TGT_BUS_SIZE-1:0] w_rs1_hit, w_rs2_hit;
  xlen_t w_rs1, w_rs2, w_result;
  logic  w_is_mul;
  logic  r_ex3_wr;
  rnid_t r_ex3_rd;
  xlen_t r_ex3_result;
  logic [RV_ENTRY_SIZE-1:0] r_ex3_index;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_valid;
      r_ex2_valid <= r_ex1_valid;
      r_ex3_valid <= r_ex2_valid & ~w_is_mul;   // Multiplies finish in mul_pipe
    end
  end

  // ------------------------------------------------------------------------
  // EX1 register read
  // ------------------------------------------------------------------------
  assign o_rs1_read = r_ex1_valid & r_ex1.rs1_used;
  assign o_rs1_rnid = r_ex1.rs1;
  assign o_rs2_read = r_ex1_valid & r_ex1.rs2_used;
  assign o_rs2_rnid = r_ex1.rs2;

  always_comb begin
    case (r_ex1.imm)
      IMM_I:   w_ex1_rs2 = {{(XLEN-12){r_ex1.inst[31]}}, r_ex1.inst[31:20]};
      IMM_SH:  w_ex1_rs2 = {{(XLEN-SH_W){1'b0}}, r_ex1.inst[20 +: SH_W]};
      default: w_ex1_rs2 = i_rs2_data;
    endcase
  end

  always_ff @(posedge i_clk) begin
    r_ex1 <= '{inst: i_inst, pc: i_pc, op: i_op, imm: i_imm, wr: i_wr,
               rs1: i_rs1_rnid, rs1_used: i_rs1_used, rs2: i_rs2_rnid,
               rs2_used: i_rs2_used, rd: i_rd_rnid, index: i_index};
    r_ex2     <= r_ex1;
    r_ex2_rs1 <= i_rs1_data;
    r_ex2_rs2 <= w_ex1_rs2;
  end

  // ------------------------------------------------------------------------
  // EX2 forwarding and ALU
  // ------------------------------------------------------------------------
  for (genvar b = 0; b < TGT_BUS_SIZE; b++) begin : g_fwd
    assign w_rs1_hit[b] = i_fwd_valid[b] & r_ex2.rs1_used &
                          (i_fwd_rnid[b] == r_ex2.rs1) & (r_ex2.rs1 != '0);
    assign w_rs2_hit[b] = i_fwd_valid[b] & r_ex2.rs2_used & (r_ex2.imm == IMM_NONE) &
                          (i_fwd_rnid[b] == r_ex2.rs2) & (r_ex2.rs2 != '0);
  end

  always_comb begin
    w_rs1 = r_ex2_rs1;
    w_rs2 = r_ex2_rs2;
    for (int b = 0; b < TGT_BUS_SIZE; b++) begin
      if (w_rs1_hit[b]) w_rs1 = i_fwd_data[b];
      if (w_rs2_hit[b]) w_rs2 = i_fwd_data[b];
    end
  end

  always_comb begin
    case (r_ex2.op)
      OP_LUI:   w_result = {r_ex2.inst[31:12], 12'h000};
      OP_AUIPC: w_result = r_ex2.pc + {r_ex2.inst[31:12], 12'h000};
      OP_ADD:   w_result = w_rs1 + w_rs2;
      OP_SUB:   w_result = w_rs1 - w_rs2;
      OP_XOR:   w_result = w_rs1 ^ w_rs2;
      OP_OR:    w_result = w_rs1 | w_rs2;
      OP_AND:   w_result = w_rs1 & w_rs2;
      OP_SLL:   w_result = w_rs1 << w_rs2[SH_W-1:0];
      OP_SRL:   w_result = w_rs1 >> w_rs2[SH_W-1:0];
      OP_SRA:   w_result = $signed(w_rs1) >>> w_rs2[SH_W-1:0];
      OP_SLT:   w_result = XLEN'($signed(w_rs1) < $signed(w_rs2));
      OP_SLTU:  w_result = XLEN'(w_rs1 < w_rs2);
      default:  w_result = '0;
    endcase
  end

  assign w_is_mul = r_ex2.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};

  assign mul.valid   = r_ex2_valid & w_is_mul;
  assign mul.op      = r_ex2.op;
  assign mul.rs1     = w_rs1;
  assign mul.rs2     = w_rs2;
  assign mul.rd_rnid = r_ex2.rd;
  assign mul.wr      = r_ex2.wr;
  assign mul.index   = r_ex2.index;

  // EX3 result
  always_ff @(posedge i_clk) begin
    r_ex3_result <= w_result;
    r_ex3_wr     <= r_ex2.wr;
    r_ex3_rd     <= r_ex2.rd;
    r_ex3_index  <= r_ex2.index;
  end

  assign wb.done     = r_ex3_valid;
  assign wb.wr       = r_ex3_wr;
  assign wb.rd_rnid  = r_ex3_rd;
  assign wb.data     = r_ex3_result;
  assign wb.index_oh = r_ex3_index;

  // Result buses never carry the same register twice
  a_fwd_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex2_valid |-> $onehot0(w_rs1_hit) && $onehot0(w_rs2_hit));

endmodule

`default_nettype wire

//--- src/mul_pipe.sv
`default_nettype none

module mul_pipe
  import alu_pipe_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8,
  parameter int MUL_UNROLL    = 8
) (
  input  wire       i_clk,
  input  wire       i_reset_n,
  mul_req_if.slave  req,
  wb_if.master      wb,
  output logic      o_issue_stall
);

  localparam int STAGES = XLEN / MUL_UNROLL;
  localparam int PW     = 2 * XLEN;

  typedef struct packed {
    op_t                      op;
    rnid_t                    rd;
    logic                     wr;
    logic [RV_ENTRY_SIZE-1:0] index;
    logic [PW-1:0]            a;     // rs1, sign or zero extended
    logic [XLEN:0]            b;     // rs2 with one extension bit
    logic [PW-1:0]            acc;
  } stage_t;

  logic [STAGES-1:0] r_valid;
  stage_t            r_st [STAGES];
  logic              w_a_sign, w_b_sign;

  assign w_a_sign = (req.op inside {OP_MULH, OP_MULHSU}) & req.rs1[XLEN-1];
  assign w_b_sign = (req.op == OP_MULH) & req.rs2[XLEN-1];

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) r_valid <= '0;
    else            r_valid <= (r_valid << 1) | STAGES'(req.valid);
  end

  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    stage_t        w_in, w_out;
    logic [PW-1:0] w_part, w_neg;

    if (s == 0) begin : g_head
      assign w_in = '{op: req.op, rd: req.rd_rnid, wr: req.wr, index: req.index,
                      a: {{XLEN{w_a_sign}}, req.rs1}, b: {w_b_sign, req.rs2}, acc: '0};
    end else begin : g_link
      assign w_in = r_st[s-1];
    end

    assign w_part = w_in.a * PW'(w_in.b[s*MUL_UNROLL +: MUL_UNROLL]);

    if (s == STAGES - 1) begin : g_top
      assign w_neg = w_in.b[XLEN] ? {w_in.a[XLEN-1:0], {XLEN{1'b0}}} : '0;   // -2^XLEN weight
    end else begin : g_mid
      assign w_neg = '0;
    end

    always_comb begin
      w_out     = w_in;
      w_out.acc = w_in.acc + (w_part << (s * MUL_UNROLL)) - w_neg;
    end

    always_ff @(posedge i_clk) begin
      r_st[s] <= w_out;
    end
  end

  // Issue now would meet this multiply at write-back
  assign o_issue_stall = r_valid[0];

  assign wb.done     = r_valid[STAGES-1];
  assign wb.wr       = r_st[STAGES-1].wr;
  assign wb.rd_rnid  = r_st[STAGES-1].rd;
  assign wb.index_oh = r_st[STAGES-1].index;
  assign wb.data     = (r_st[STAGES-1].op == OP_MUL) ? r_st[STAGES-1].acc[XLEN-1:0] :
                                                       r_st[STAGES-1].acc[PW-1:XLEN];

  a_mul_op: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    req.valid |-> req.op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU});

endmodule

`default_nettype wire

//--- src/wb_merge.sv
`default_nettype none

module wb_merge
  import alu_pipe_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8
) (
  wb_if.slave                      alu,
  wb_if.slave                      mul,
  output logic                     o_done_valid,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index,
  output logic                     o_wr_valid,
  output rnid_t                    o_wr_rnid,
  output xlen_t                    o_wr_data
);

  always_comb begin
    if (mul.done) begin
      o_done_valid = 1'b1;
      o_done_index = mul.index_oh;
      o_wr_valid   = mul.wr;
      o_wr_rnid    = mul.rd_rnid;
      o_wr_data    = mul.data;
    end else begin
      o_done_valid = alu.done;
      o_done_index = alu.index_oh;
      o_wr_valid   = alu.done & alu.wr;
      o_wr_rnid    = alu.rd_rnid;
      o_wr_data    = alu.data;
    end
  end

  // Issue stall keeps the two paths apart
  always_comb begin
    a_no_collision: assert (!(alu.done && mul.done));
  end

endmodule

`default_nettype wire

//--- src/alu_pipe_top.sv
`default_nettype none

module alu_pipe_top
  import alu_pipe_pkg::*;
#(
  parameter int RV_ENTRY_SIZE = 8,
  parameter int MUL_UNROLL    = alu_pipe_pkg::MUL_UNROLL
) (
  input  wire                      i_clk,
  input  wire                      i_reset_n,
  input  wire                      i_issue_valid,
  input  wire xlen_t               i_issue_inst,
  input  wire xlen_t               i_issue_pc,
  input  wire rnid_t               i_rs1_rnid,
  input  wire                      i_rs1_used,
  input  wire rnid_t               i_rs2_rnid,
  input  wire                      i_rs2_used,
  input  wire rnid_t               i_rd_rnid,
  input  wire [RV_ENTRY_SIZE-1:0]  i_issue_index,
  input  wire                      i_fwd_valid [TGT_BUS_SIZE],
  input  wire rnid_t               i_fwd_rnid  [TGT_BUS_SIZE],
  input  wire xlen_t               i_fwd_data  [TGT_BUS_SIZE],
  output logic                     o_rs1_read,
  output rnid_t                    o_rs1_rnid,
  output logic                     o_rs2_read,
  output rnid_t                    o_rs2_rnid,
  input  wire xlen_t               i_rs1_data,
  input  wire xlen_t               i_rs2_data,
  output logic                     o_wr_valid,
  output rnid_t                    o_wr_rnid,
  output xlen_t                    o_wr_data,
  output logic                     o_done_valid,
  output logic [RV_ENTRY_SIZE-1:0] o_done_index,
  output logic                     o_issue_stall
);

  op_t  w_ex0_op;
  imm_t w_ex0_imm;
  logic w_ex0_wr;

  mul_req_if #(.RV_ENTRY_SIZE(RV_ENTRY_SIZE)) u_mul_req ();
  wb_if      #(.RV_ENTRY_SIZE(RV_ENTRY_SIZE)) u_alu_wb ();
  wb_if      #(.RV_ENTRY_SIZE(RV_ENTRY_SIZE)) u_mul_wb ();

  alu_decoder u_decoder (
    .i_inst (i_issue_inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm),
    .o_wr   (w_ex0_wr)
  );

  int_exec_pipe #(.RV_ENTRY_SIZE(RV_ENTRY_SIZE)) u_int_pipe (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_valid    (i_issue_valid),
    .i_inst     (i_issue_inst),
    .i_pc       (i_issue_pc),
    .i_op       (w_ex0_op),
    .i_imm      (w_ex0_imm),
    .i_wr       (w_ex0_wr),
    .i_rs1_rnid (i_rs1_rnid),
    .i_rs1_used (i_rs1_used),
    .i_rs2_rnid (i_rs2_rnid),
    .i_rs2_used (i_rs2_used),
    .i_rd_rnid  (i_rd_rnid),
    .i_index    (i_issue_index),
    .o_rs1_read (o_rs1_read),
    .o_rs1_rnid (o_rs1_rnid),
    .o_rs2_read (o_rs2_read),
    .o_rs2_rnid (o_rs2_rnid),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .i_fwd_valid(i_fwd_valid),
    .i_fwd_rnid (i_fwd_rnid),
    .i_fwd_data (i_fwd_data),
    .mul        (u_mul_req.master),
    .wb         (u_alu_wb.master)
  );

  mul_pipe #(
    .RV_ENTRY_SIZE(RV_ENTRY_SIZE),
    .MUL_UNROLL   (MUL_UNROLL)
  ) u_mul_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .req          (u_mul_req.slave),
    .wb           (u_mul_wb.master),
    .o_issue_stall(o_issue_stall)
  );

  wb_merge #(.RV_ENTRY_SIZE(RV_ENTRY_SIZE)) u_merge (
    .alu         (u_alu_wb.slave),
    .mul         (u_mul_wb.slave),
    .o_done_valid(o_done_valid),
    .o_done_index(o_done_index),
    .o_wr_valid  (o_wr_valid),
    .o_wr_rnid   (o_wr_rnid),
    .o_wr_data   (o_wr_data)
  );

endmodule

`default_nettype wire

//--- sim/tb_alu_pipe.sv
`default_nettype none

module tb_alu_pipe;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [5:0]  rs1;
    logic        rs1_used;
    logic [5:0]  rs2;
    logic        rs2_used;
    logic [5:0]  rd;
    int          fbus;
    logic        fen;
    logic [5:0]  frn;
    logic [31:0] fval;
    logic        wr;
  } row_t;

  typedef struct {
    logic [7:0]  index;
    logic [5:0]  rd;
    logic [31:0] data;
    logic        wr;
  } exp_t;

  logic        i_clk = 1'b0;
  logic        i_reset_n;
  logic        issue_valid;
  logic [31:0] issue_inst, issue_pc, rs1_data, rs2_data;
  logic [5:0]  rs1_rnid, rs2_rnid, rd_rnid;
  logic        rs1_used, rs2_used;
  logic [7:0]  issue_index;
  logic        fwd_valid [2];
  logic [5:0]  fwd_rnid  [2];
  logic [31:0] fwd_data  [2];
  logic        rs1_read, rs2_read, wr_valid, done_valid, issue_stall;
  logic [5:0]  rd1_rnid, rd2_rnid, wr_rnid;
  logic [31:0] wr_data;
  logic [7:0]  done_index;

  logic [31:0] regs [64];
  row_t        rows [$];
  exp_t        exp_at [int];
  bit          mul_at [int];
  int          row_at [int];
  int          cyc = 0;
  int          pending = 0;
  int          limit = 1000;

  always #5 i_clk = ~i_clk;

  always @(posedge i_clk) cyc <= cyc + 1;

  // Register file answers in the same cycle
  assign rs1_data = regs[rd1_rnid];
  assign rs2_data = regs[rd2_rnid];

  alu_pipe_top #(.RV_ENTRY_SIZE(8), .MUL_UNROLL(8)) DUT (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_issue_valid(issue_valid),
    .i_issue_inst(issue_inst), .i_issue_pc(issue_pc),
    .i_rs1_rnid(rs1_rnid), .i_rs1_used(rs1_used),
    .i_rs2_rnid(rs2_rnid), .i_rs2_used(rs2_used),
    .i_rd_rnid(rd_rnid), .i_issue_index(issue_index),
    .i_fwd_valid(fwd_valid), .i_fwd_rnid(fwd_rnid), .i_fwd_data(fwd_data),
    .o_rs1_read(rs1_read), .o_rs1_rnid(rd1_rnid),
    .o_rs2_read(rs2_read), .o_rs2_rnid(rd2_rnid),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_wr_valid(wr_valid), .o_wr_rnid(wr_rnid), .o_wr_data(wr_data),
    .o_done_valid(done_valid), .o_done_index(done_index),
    .o_issue_stall(issue_stall)
  );

  task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("tests failed");
      $fatal(1, "compare failed");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s at %0t", why, $time);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {imm, 5'd1, f3, rd, 7'b0010011};
  endfunction

  task automatic add_row(input logic [31:0] inst, input logic [31:0] pc,
                         input logic [5:0] rs1, input logic u1, input logic [5:0] rs2,
                         input logic u2, input logic [5:0] rd, input int fbus,
                         input logic fen, input logic [5:0] frn, input logic [31:0] fval,
                         input logic wr);
    row_t r;
    r = '{inst, pc, rs1, u1, rs2, u2, rd, fbus, fen, frn, fval, wr};
    rows.push_back(r);
  endtask

  // RISC-V reference for one instruction, operands already resolved
  function automatic logic [31:0] ref_result(input logic [31:0] inst, input logic [31:0] pc,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm;
    logic [4:0]  sh;
    logic [63:0] p;
    opc = inst[6:0];
    f3  = inst[14:12];
    f7  = inst[31:25];
    imm = {{20{inst[31]}}, inst[31:20]};
    sh  = inst[24:20];
    if (opc == 7'b0110111) return {inst[31:12], 12'h0};
    if (opc == 7'b0010111) return pc + {inst[31:12], 12'h0};
    if (opc == 7'b0010011) begin
      case (f3)
        3'd0: return a + imm;
        3'd2: return {31'd0, $signed(a) < $signed(imm)};
        3'd3: return {31'd0, a < imm};
        3'd4: return a ^ imm;
        3'd6: return a | imm;
        3'd7: return a & imm;
        3'd1: return (f7 == 7'h00) ? a << sh : 32'd0;
        default: return (f7 == 7'h00) ? a >> sh :
                        (f7 == 7'h20) ? 32'($signed(a) >>> sh) : 32'd0;
      endcase
    end
    if (opc != 7'b0110011) return 32'd0;
    if (f7 == 7'h01) begin
      case (f3)
        3'd0: p = {32'd0, a} * {32'd0, b};
        3'd1: p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        3'd2: p = {{32{a[31]}}, a} * {32'd0, b};
        3'd3: p = {32'd0, a} * {32'd0, b};
        default: return 32'd0;
      endcase
      return (f3 == 3'd0) ? p[31:0] : p[63:32];
    end
    case ({f7, f3})
      10'h000: return a + b;
      10'h100: return a - b;
      10'h001: return a << b[4:0];
      10'h002: return {31'd0, $signed(a) < $signed(b)};
      10'h003: return {31'd0, a < b};
      10'h004: return a ^ b;
      10'h005: return a >> b[4:0];
      10'h105: return 32'($signed(a) >>> b[4:0]);
      10'h006: return a | b;
      10'h007: return a & b;
      default: return 32'd0;
    endcase
  endfunction

  task automatic issue_row(input int idx, input int k);
    row_t        r;
    exp_t        e;
    logic [31:0] a, b;
    bit          is_mul, is_imm;
    r      = rows[idx];
    is_mul = (r.inst[6:0] == 7'b0110011) && (r.inst[31:25] == 7'h01) && !r.inst[14];
    is_imm = (r.inst[6:0] == 7'b0010011);
    a = regs[r.rs1];
    b = regs[r.rs2];
    if (r.fen && r.rs1_used && r.frn == r.rs1 && r.rs1 != 0) a = r.fval;
    if (r.fen && r.rs2_used && !is_imm && r.frn == r.rs2 && r.rs2 != 0) b = r.fval;
    e = '{8'(1 << (idx % 8)), r.rd, ref_result(r.inst, r.pc, a, b), r.wr};
    exp_at[k + (is_mul ? 6 : 3)] = e;
    row_at[k] = idx;
    if (is_mul) mul_at[k] = 1'b1;
    pending++;
    issue_valid <= 1'b1;
    issue_inst  <= r.inst;
    issue_pc    <= r.pc;
    rs1_rnid    <= r.rs1;
    rs1_used    <= r.rs1_used;
    rs2_rnid    <= r.rs2;
    rs2_used    <= r.rs2_used;
    rd_rnid     <= r.rd;
    issue_index <= 8'(1 << (idx % 8));
  endtask

  // Result bus entry for the row sitting in EX2
  task automatic drive_fwd(input int k);
    row_t r;
    for (int b = 0; b < 2; b++) fwd_valid[b] <= 1'b0;
    if (row_at.exists(k - 2)) begin
      r = rows[row_at[k - 2]];
      if (r.fen) begin
        fwd_valid[r.fbus] <= 1'b1;
        fwd_rnid[r.fbus]  <= r.frn;
        fwd_data[r.fbus]  <= r.fval;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Completion and stall checker
  // --------------------------------------------------------------------------
  always @(negedge i_clk) begin
    if (i_reset_n) begin
      check("o_issue_stall", 64'(issue_stall), 64'(mul_at.exists(cyc - 3)));
      // Register read happens for the row in EX1
      if (row_at.exists(cyc - 1)) begin
        check("o_rs1_read", 64'(rs1_read), 64'(rows[row_at[cyc - 1]].rs1_used));
        check("o_rs2_read", 64'(rs2_read), 64'(rows[row_at[cyc - 1]].rs2_used));
        check("o_rs1_rnid", 64'(rd1_rnid), 64'(rows[row_at[cyc - 1]].rs1));
        check("o_rs2_rnid", 64'(rd2_rnid), 64'(rows[row_at[cyc - 1]].rs2));
      end else begin
        check("o_rs1_read", 64'(rs1_read), 64'(0));
        check("o_rs2_read", 64'(rs2_read), 64'(0));
      end
      if (done_valid) begin
        if (!exp_at.exists(cyc)) begin
          fail_run("Unexpected completion");
        end else begin
          check("o_done_index", 64'(done_index), 64'(exp_at[cyc].index));
          check("o_wr_valid", 64'(wr_valid), 64'(exp_at[cyc].wr));
          check("o_wr_rnid", 64'(wr_rnid), 64'(exp_at[cyc].rd));
          check("o_wr_data", 64'(wr_data), 64'(exp_at[cyc].data));
          exp_at.delete(cyc);
          pending--;
        end
      end else if (exp_at.exists(cyc)) begin
        fail_run("Expected completion did not appear");
      end
    end
  end

  always @(posedge i_clk) begin
    if (cyc > limit) fail_run("Timeout, not all instructions completed");
  end

  initial begin
    int next;
    int k;
    i_reset_n   = 1'b0;
    issue_valid = 1'b0;
    issue_inst  = '0;
    issue_pc    = '0;
    rs1_rnid    = '0;
    rs1_used    = 1'b0;
    rs2_rnid    = '0;
    rs2_used    = 1'b0;
    rd_rnid     = '0;
    issue_index = '0;
    for (int b = 0; b < 2; b++) begin
      fwd_valid[b] = 1'b0;
      fwd_rnid[b]  = '0;
      fwd_data[b]  = '0;
    end
    void'($urandom(32'h28c2));
    for (int i = 0; i < 64; i++) regs[i] = $urandom;
    regs[0]  = '0;
    regs[60] = 32'h8000_0000;   // Signed corners
    regs[61] = 32'hffff_ffff;
    regs[62] = 32'h7fff_ffff;

    add_row(enc_r(7'h00, 3'd0, 5'd1), 0, 5, 1, 6, 1, 10, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h20, 3'd0, 5'd1), 0, 7, 1, 8, 1, 11, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd4, 5'd1), 0, 9, 1, 10, 1, 12, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd6, 5'd1), 0, 11, 1, 12, 1, 13, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd7, 5'd1), 0, 13, 1, 14, 1, 14, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd1, 5'd1), 0, 15, 1, 16, 1, 15, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd5, 5'd1), 0, 60, 1, 17, 1, 16, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h20, 3'd5, 5'd1), 0, 60, 1, 18, 1, 17, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd2, 5'd1), 0, 60, 1, 61, 1, 18, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd3, 5'd1), 0, 60, 1, 61, 1, 19, 0, 0, 0, 0, 1);
    // Immediate forms, rs2 bus hit must be ignored
    add_row(enc_i(12'hffb, 3'd0, 5'd1), 0, 12, 1, 13, 1, 20, 0, 1, 13, 32'h1234, 1);
    add_row(enc_i(12'h7ff, 3'd2, 5'd1), 0, 61, 1, 0, 0, 21, 0, 0, 0, 0, 1);
    add_row(enc_i(12'h404, 3'd5, 5'd1), 0, 60, 1, 0, 0, 22, 0, 0, 0, 0, 1);
    add_row(enc_i(12'h01f, 3'd1, 5'd1), 0, 19, 1, 0, 0, 23, 0, 0, 0, 0, 1);
    add_row({20'habcde, 5'd1, 7'b0110111}, 0, 0, 0, 0, 0, 24, 0, 0, 0, 0, 1);
    add_row({20'h12345, 5'd1, 7'b0010111}, 32'h1000, 0, 0, 0, 0, 25, 0, 0, 0, 0, 1);
    // Forwarding
    add_row(enc_r(7'h00, 3'd0, 5'd1), 0, 14, 1, 20, 1, 26, 0, 1, 14, 32'hdeadbeef, 1);
    add_row(enc_r(7'h00, 3'd0, 5'd1), 0, 21, 1, 15, 1, 27, 1, 1, 15, 32'h100, 1);
    add_row(enc_r(7'h00, 3'd0, 5'd1), 0, 0, 1, 22, 1, 28, 0, 1, 0, 32'h5555, 1);
    add_row(enc_r(7'h00, 3'd0, 5'd1), 0, 16, 1, 17, 1, 29, 1, 1, 20, 32'h7777, 1);
    // Multiplies back to back
    add_row(enc_r(7'h01, 3'd0, 5'd1), 0, 60, 1, 61, 1, 30, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h01, 3'd1, 5'd1), 0, 60, 1, 60, 1, 31, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h01, 3'd2, 5'd1), 0, 61, 1, 62, 1, 32, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h01, 3'd3, 5'd1), 0, 61, 1, 61, 1, 33, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h00, 3'd0, 5'd1), 0, 23, 1, 24, 1, 34, 0, 0, 0, 0, 1);
    add_row(enc_r(7'h01, 3'd1, 5'd1), 0, 62, 1, 18, 1, 35, 1, 1, 18, 32'h8000_0000, 1);
    add_row(enc_i(12'h003, 3'd0, 5'd1), 0, 25, 1, 0, 0, 36, 0, 0, 0, 0, 1);
    // No write
    add_row(32'hffff_ffff, 0, 26, 1, 27, 1, 37, 0, 0, 0, 0, 0);
    add_row(enc_r(7'h00, 3'd0, 5'd0), 0, 28, 1, 29, 1, 38, 0, 0, 0, 0, 0);
    limit = 8 * rows.size() + 50;

    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;
    next = 0;
    while (next < rows.size() || pending != 0) begin
      @(posedge i_clk);
      k = cyc + 1;
      drive_fwd(k);
      if (next < rows.size() && !mul_at.exists(k - 3)) begin
        issue_row(next, k);
        next++;
      end else begin
        issue_valid <= 1'b0;
      end
    end
    repeat (2) @(posedge i_clk);
    if (exp_at.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "results left over");
    end
  end

endmodule

`default_nettype wire

//--- sim.f
src/alu_pipe_pkg.sv
src/mul_req_if.sv
src/wb_if.sv
src/alu_decoder.sv
src/int_exec_pipe.sv
src/mul_pipe.sv
src/wb_merge.sv
src/alu_pipe_top.sv
sim/tb_alu_pipe.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 \
  --top-module tb_alu_pipe \
  -f sim.f \
  -o Vtb_alu_pipe
./obj_dir/Vtb_alu_pipe
